//--- source/armIsaPkg.sv
package armIsaPkg;

  // Datapath and instruction word width
  localparam int instrWidth = 32;

  // ====================================================================
  // Instruction field positions
  // ====================================================================
  localparam int condHi  = 31;  // Condition field
  localparam int condLo  = 28;
  localparam int classHi = 27;  // Instruction class
  localparam int classLo = 26;
  localparam int immBit  = 25;  // I bit
  localparam int upBit   = 23;  // U bit adds or subtracts the offset
  localparam int byteBit = 22;  // B bit selects a byte transfer
  localparam int sBit    = 20;  // S bit on data processing
  localparam int loadBit = 20;  // L bit on load/store shares the S position
  localparam int rdHi    = 15;  // Destination register
  localparam int rdLo    = 12;
  localparam int opHi    = 24;  // Data-processing opcode
  localparam int opLo    = 21;

  localparam logic [3:0] pcReg = 4'd15;  // r15 is the PC

  // Class codes in bits 27:26
  localparam logic [1:0] clsDataProc  = 2'b00;
  localparam logic [1:0] clsLoadStore = 2'b01;
  localparam logic [1:0] clsBranch    = 2'b10;

  // Condition codes in architectural encoding
  typedef enum logic [3:0] {
    condEq, condNe, condCs, condCc, condMi, condPl, condVs, condVc,
    condHigh, condLs, condGe, condLt, condGt, condLe, condAl
  } condT;

  // Data-processing opcodes
  typedef enum logic [3:0] {
    opAnd, opEor, opSub, opRsb, opAdd, opAdc, opSbc, opRsc,
    opTst, opTeq, opCmp, opCmn, opOrr, opMov, opBic, opMvn
  } dpOpT;

endpackage

//--- source/ctrlPkg.sv
package ctrlPkg;

  localparam int byteMaskWidth = 4;  // One lane per byte of the data word

  // Flag-write mode, bit 1 updates NZ and bit 0 updates CV
  typedef enum logic [1:0] {
    fwNone = 2'b00,
    fwNz   = 2'b10,  // Logical ops keep C and V
    fwAll  = 2'b11
  } flagWriteT;

  // Register file read selects
  typedef enum logic [1:0] {
    regDefault = 2'b00,  // Rn and Rm from instruction
    regBranch  = 2'b01,  // PC on first read port
    regStore   = 2'b10   // Rd on second port as store data
  } regSrcT;

  // Immediate extension selects
  typedef enum logic [1:0] {
    immDp     = 2'b00,  // 8-bit rotated immediate
    immMem    = 2'b01,  // 12-bit offset
    immBranch = 2'b10   // 24-bit word offset
  } immSrcT;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  // ====================================================================
  // Stage bundles
  // ====================================================================
  typedef struct packed {
    logic                     memWrite;
    logic                     memToReg;
    logic                     regWrite;
    logic                     pcSrc;
    logic [byteMaskWidth-1:0] byteMask;
    logic                     byteAccess;
    logic [1:0]               byteOffset;
    logic                     setFlags;
    flagsT                    flagsNext;
  } memStageT;

  typedef struct packed {
    logic       memToReg;
    logic       regWrite;
    logic       pcSrc;
    logic       byteAccess;  // Byte load aligner enable
    logic [1:0] byteOffset;
    logic       setFlags;
    flagsT      flagsNext;
  } wbStageT;

endpackage

//--- source/execCtrlIf.sv
`timescale 1ns/1ps

interface execCtrlIf;

  // Decoded control registered into execute
  armIsaPkg::condT    cond;
  logic               regWrite;
  logic               memWrite;
  logic               memToReg;
  logic               branch;
  logic               pcSrc;
  ctrlPkg::flagWriteT flagWrite;
  logic               byteAccess;
  logic               store;

  ctrlPkg::flagsT     flagsE;     // Forwarded flags seen by execute
  logic               condEx;     // Condition passed
  ctrlPkg::flagsT     flagsNext;  // Flags after this instruction
  logic               setFlags;

  modport decoder (
    output cond, regWrite, memWrite, memToReg, branch, pcSrc, flagWrite, byteAccess, store
  );

  modport check (input cond, flagWrite, flagsE, output condEx, flagsNext, setFlags);

  modport mask (input byteAccess, store);

  modport pipe (
    input  regWrite, memWrite, memToReg, branch, pcSrc, byteAccess, condEx, flagsNext,
    input  setFlags,
    output flagsE
  );

endinterface

//--- source/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [armIsaPkg::instrWidth-1:0] instrD,
  input  logic                             stallE,
  input  logic                             flushE,
  output ctrlPkg::regSrcT                  regSrcD,
  output ctrlPkg::immSrcT                  immSrcD,
  output logic                             aluSrcE,
  output armIsaPkg::dpOpT                  aluControlE,
  output logic                             pcSrcD,
  execCtrlIf.decoder                       ex
);

  armIsaPkg::dpOpT    opcode;
  armIsaPkg::dpOpT    aluControlD;
  ctrlPkg::flagWriteT flagWriteD;
  logic               arithOp;     // Opcode produces C and V
  logic               testOp;      // Opcode writes flags only
  logic               rdIsPc;
  logic               aluSrcD;
  logic               regWriteD;
  logic               memWriteD;
  logic               memToRegD;
  logic               branchD;
  logic               byteAccessD;
  logic               storeD;

  assign opcode = armIsaPkg::dpOpT'(instrD[armIsaPkg::opHi:armIsaPkg::opLo]);
  assign rdIsPc = (instrD[armIsaPkg::rdHi:armIsaPkg::rdLo] == armIsaPkg::pcReg);

  // Opcode groups
  always_comb begin
    arithOp = 1'b0;
    testOp  = 1'b0;
    case (opcode)
      armIsaPkg::opSub, armIsaPkg::opRsb, armIsaPkg::opAdd,
      armIsaPkg::opAdc, armIsaPkg::opSbc, armIsaPkg::opRsc: arithOp = 1'b1;
      armIsaPkg::opCmp, armIsaPkg::opCmn: begin
        arithOp = 1'b1;
        testOp  = 1'b1;
      end
      armIsaPkg::opTst, armIsaPkg::opTeq: testOp = 1'b1;
      armIsaPkg::opAnd, armIsaPkg::opEor, armIsaPkg::opOrr,
      armIsaPkg::opMov, armIsaPkg::opBic, armIsaPkg::opMvn: arithOp = 1'b0;  // Logical
      default: arithOp = 1'b0;
    endcase
  end

  // ====================================================================
  // Decode stage control
  // ====================================================================
  always_comb begin
    regSrcD     = ctrlPkg::regDefault;
    immSrcD     = ctrlPkg::immDp;
    aluSrcD     = 1'b0;
    aluControlD = armIsaPkg::opAdd;  // Address and target arithmetic
    regWriteD   = 1'b0;
    memWriteD   = 1'b0;
    memToRegD   = 1'b0;
    branchD     = 1'b0;
    flagWriteD  = ctrlPkg::fwNone;
    byteAccessD = 1'b0;
    storeD      = 1'b0;
    case (instrD[armIsaPkg::classHi:armIsaPkg::classLo])
      armIsaPkg::clsDataProc: begin
        aluSrcD     = instrD[armIsaPkg::immBit];  // Immediate form
        aluControlD = opcode;                     // ALU takes the opcode as is
        regWriteD   = ~testOp;
        if (instrD[armIsaPkg::sBit]) begin
          if (arithOp) begin
            flagWriteD = ctrlPkg::fwAll;
          end else begin
            flagWriteD = ctrlPkg::fwNz;
          end
        end
      end
      armIsaPkg::clsLoadStore: begin
        immSrcD     = ctrlPkg::immMem;
        aluSrcD     = ~instrD[armIsaPkg::immBit];  // I clear selects 12-bit offset
        byteAccessD = instrD[armIsaPkg::byteBit];
        if (!instrD[armIsaPkg::upBit]) begin
          aluControlD = armIsaPkg::opSub;  // Rn minus offset
        end
        if (instrD[armIsaPkg::loadBit]) begin
          regWriteD = 1'b1;
          memToRegD = 1'b1;
        end else begin
          regSrcD   = ctrlPkg::regStore;
          memWriteD = 1'b1;
          storeD    = 1'b1;
        end
      end
      armIsaPkg::clsBranch: begin
        regSrcD = ctrlPkg::regBranch;  // PC + offset
        immSrcD = ctrlPkg::immBranch;
        aluSrcD = 1'b1;
        branchD = 1'b1;
      end
      default: branchD = 1'b0;  // Coprocessor and SWI space decode as no-op
    endcase
  end

  // Branches and any register write to r15 redirect fetch
  assign pcSrcD = branchD | (regWriteD & rdIsPc);

  // ====================================================================
  // Decode to execute register
  // ====================================================================
  always_ff @(posedge clk) begin
    if (rst || flushE) begin  // Bubble
      ex.regWrite   <= 1'b0;
      ex.memWrite   <= 1'b0;
      ex.memToReg   <= 1'b0;
      ex.branch     <= 1'b0;
      ex.pcSrc      <= 1'b0;
      ex.flagWrite  <= ctrlPkg::fwNone;
      ex.byteAccess <= 1'b0;
      ex.store      <= 1'b0;
    end else if (!stallE) begin
      ex.regWrite   <= regWriteD;
      ex.memWrite   <= memWriteD;
      ex.memToReg   <= memToRegD;
      ex.branch     <= branchD;
      ex.pcSrc      <= pcSrcD;
      ex.flagWrite  <= flagWriteD;
      ex.byteAccess <= byteAccessD;
      ex.store      <= storeD;
    end
  end

  // Payload registers follow stallE only
  always_ff @(posedge clk) begin
    if (!stallE) begin
      ex.cond     <= armIsaPkg::condT'(instrD[armIsaPkg::condHi:armIsaPkg::condLo]);
      aluSrcE     <= aluSrcD;
      aluControlE <= aluControlD;
    end
  end

endmodule

//--- source/condCheck.sv
`timescale 1ns/1ps

module condCheck (
  input  ctrlPkg::flagsT aluFlagsE,
  execCtrlIf.check       ex
);

  // Standard condition table on forwarded NZCV
  always_comb begin
    case (ex.cond)
      armIsaPkg::condEq:   ex.condEx = ex.flagsE.z;
      armIsaPkg::condNe:   ex.condEx = ~ex.flagsE.z;
      armIsaPkg::condCs:   ex.condEx = ex.flagsE.c;
      armIsaPkg::condCc:   ex.condEx = ~ex.flagsE.c;
      armIsaPkg::condMi:   ex.condEx = ex.flagsE.n;
      armIsaPkg::condPl:   ex.condEx = ~ex.flagsE.n;
      armIsaPkg::condVs:   ex.condEx = ex.flagsE.v;
      armIsaPkg::condVc:   ex.condEx = ~ex.flagsE.v;
      armIsaPkg::condHigh: ex.condEx = ex.flagsE.c & ~ex.flagsE.z;  // Unsigned higher
      armIsaPkg::condLs:   ex.condEx = ~ex.flagsE.c | ex.flagsE.z;
      armIsaPkg::condGe:   ex.condEx = (ex.flagsE.n == ex.flagsE.v);  // Signed compares
      armIsaPkg::condLt:   ex.condEx = (ex.flagsE.n != ex.flagsE.v);
      armIsaPkg::condGt:   ex.condEx = ~ex.flagsE.z & (ex.flagsE.n == ex.flagsE.v);
      armIsaPkg::condLe:   ex.condEx = ex.flagsE.z | (ex.flagsE.n != ex.flagsE.v);
      armIsaPkg::condAl:   ex.condEx = 1'b1;
      default:             ex.condEx = 1'b0;  // 1111 space never executes here
    endcase
  end

  // Merge new ALU flags by write mode
  always_comb begin
    case (ex.flagWrite)
      ctrlPkg::fwAll: ex.flagsNext = aluFlagsE;
      ctrlPkg::fwNz: begin
        ex.flagsNext   = ex.flagsE;  // C and V held
        ex.flagsNext.n = aluFlagsE.n;
        ex.flagsNext.z = aluFlagsE.z;
      end
      default: ex.flagsNext = ex.flagsE;
    endcase
  end

  // Failed condition leaves the flags alone
  assign ex.setFlags = (ex.flagWrite != ctrlPkg::fwNone) & ex.condEx;

endmodule

//--- source/memMask.sv
`timescale 1ns/1ps

module memMask (
  input  logic [1:0]                        addrLowE,
  output logic [ctrlPkg::byteMaskWidth-1:0] byteMaskE,
  output logic [1:0]                        byteOffsetE,
  execCtrlIf.mask                           ex
);

  // Lane enables, little-endian lane order
  always_comb begin
    if (ex.byteAccess) begin
      byteMaskE           = '0;
      byteMaskE[addrLowE] = 1'b1;  // Single lane at the byte address
    end else begin
      byteMaskE = '1;  // Word access
    end
  end

  // Offset for the writeback load aligner
  // Stores need no alignment so they carry zero
  assign byteOffsetE = ex.store ? 2'b00 : addrLowE;

endmodule

//--- source/ctrlPipe.sv
`timescale 1ns/1ps

module ctrlPipe (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              stallM,
  input  logic                              stallW,
  input  logic                              flushW,
  input  logic [ctrlPkg::byteMaskWidth-1:0] byteMaskE,
  input  logic [1:0]                        byteOffsetE,
  input  logic                              pcSrcD,
  output logic                              branchTakenE,
  output logic                              memWriteM,
  output logic                              memToRegM,
  output logic                              regWriteM,
  output logic [ctrlPkg::byteMaskWidth-1:0] byteMaskM,
  output logic                              memToRegW,
  output logic                              regWriteW,
  output logic                              pcSrcW,
  output logic                              byteLoadW,
  output logic [1:0]                        byteOffsetW,
  output ctrlPkg::flagsT                    flags,
  output logic                              pcWrPendingF,
  execCtrlIf.pipe                           ex
);

  ctrlPkg::memStageT memE;  // Execute results headed to memory
  ctrlPkg::memStageT memQ;
  ctrlPkg::wbStageT  wbD;
  ctrlPkg::wbStageT  wbQ;

  // ====================================================================
  // Execute, condition gating
  // ====================================================================
  assign branchTakenE = ex.branch & ex.condEx;

  always_comb begin
    memE.memWrite   = ex.memWrite & ex.condEx;
    memE.memToReg   = ex.memToReg;
    memE.regWrite   = ex.regWrite & ex.condEx;
    memE.pcSrc      = ex.pcSrc & ex.condEx;
    memE.byteMask   = byteMaskE;
    memE.byteAccess = ex.byteAccess;
    memE.byteOffset = byteOffsetE;
    memE.setFlags   = ex.setFlags;  // Already gated by condCheck
    memE.flagsNext  = ex.flagsNext;
  end

  // Youngest pending flag write wins
  assign ex.flagsE = memQ.setFlags ? memQ.flagsNext :
                     wbQ.setFlags  ? wbQ.flagsNext  : flags;

  // ====================================================================
  // Memory and writeback registers
  // ====================================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      memQ <= '0;
    end else if (!stallM) begin  // No flush in memory
      memQ <= memE;
    end
  end

  always_comb begin
    wbD.memToReg   = memQ.memToReg;
    wbD.regWrite   = memQ.regWrite;
    wbD.pcSrc      = memQ.pcSrc;
    wbD.byteAccess = memQ.byteAccess;
    wbD.byteOffset = memQ.byteOffset;
    wbD.setFlags   = memQ.setFlags;
    wbD.flagsNext  = memQ.flagsNext;
  end

  always_ff @(posedge clk) begin
    if (rst || flushW) begin
      wbQ <= '0;
    end else if (!stallW) begin
      wbQ <= wbD;
    end
  end

  // Architectural NZCV, updated as writeback retires
  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else if (wbQ.setFlags && !stallW) begin
      flags <= wbQ.flagsNext;
    end
  end

  assign memWriteM = memQ.memWrite;
  assign memToRegM = memQ.memToReg;
  assign regWriteM = memQ.regWrite;
  assign byteMaskM = memQ.byteMask;

  assign memToRegW   = wbQ.memToReg;
  assign regWriteW   = wbQ.regWrite;
  assign pcSrcW      = wbQ.pcSrc;
  assign byteLoadW   = wbQ.byteAccess;
  assign byteOffsetW = wbQ.byteOffset;

  // PC write somewhere ahead of writeback, fetch must hold
  assign pcWrPendingF = pcSrcD | ex.pcSrc | memQ.pcSrc;

endmodule

//--- source/armCtrlTop.sv
`timescale 1ns/1ps

module armCtrlTop (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [armIsaPkg::instrWidth-1:0]  instrD,
  input  ctrlPkg::flagsT                    aluFlagsE,
  input  logic [1:0]                        addrLowE,
  input  logic                              stallE,
  input  logic                              flushE,
  input  logic                              stallM,
  input  logic                              stallW,
  input  logic                              flushW,
  output ctrlPkg::regSrcT                   regSrcD,
  output ctrlPkg::immSrcT                   immSrcD,
  output logic                              aluSrcE,
  output armIsaPkg::dpOpT                   aluControlE,
  output logic                              branchTakenE,
  output logic                              memWriteM,
  output logic                              memToRegM,
  output logic                              regWriteM,
  output logic [ctrlPkg::byteMaskWidth-1:0] byteMaskM,
  output logic                              memToRegW,
  output logic                              regWriteW,
  output logic                              pcSrcW,
  output logic                              byteLoadW,
  output logic [1:0]                        byteOffsetW,
  output ctrlPkg::flagsT                    flags,
  output logic                              pcWrPendingF
);

  logic                              pcSrcD;
  logic [ctrlPkg::byteMaskWidth-1:0] byteMaskE;
  logic [1:0]                        byteOffsetE;

  execCtrlIf exIf ();  // Execute-stage control bundle

  // Decode stage and D/E register
  instrDecoder uDecoder (
    .clk         (clk),
    .rst         (rst),
    .instrD      (instrD),
    .stallE      (stallE),
    .flushE      (flushE),
    .regSrcD     (regSrcD),
    .immSrcD     (immSrcD),
    .aluSrcE     (aluSrcE),
    .aluControlE (aluControlE),
    .pcSrcD      (pcSrcD),
    .ex          (exIf.decoder)
  );

  // Execute stage parts working side by side
  condCheck uCond (
    .aluFlagsE (aluFlagsE),
    .ex        (exIf.check)
  );

  memMask uMask (
    .addrLowE    (addrLowE),
    .byteMaskE   (byteMaskE),
    .byteOffsetE (byteOffsetE),
    .ex          (exIf.mask)
  );

  // Condition gating plus M and W registers and the flag register
  ctrlPipe uPipe (
    .clk          (clk),
    .rst          (rst),
    .stallM       (stallM),
    .stallW       (stallW),
    .flushW       (flushW),
    .byteMaskE    (byteMaskE),
    .byteOffsetE  (byteOffsetE),
    .pcSrcD       (pcSrcD),
    .branchTakenE (branchTakenE),
    .memWriteM    (memWriteM),
    .memToRegM    (memToRegM),
    .regWriteM    (regWriteM),
    .byteMaskM    (byteMaskM),
    .memToRegW    (memToRegW),
    .regWriteW    (regWriteW),
    .pcSrcW       (pcSrcW),
    .byteLoadW    (byteLoadW),
    .byteOffsetW  (byteOffsetW),
    .flags        (flags),
    .pcWrPendingF (pcWrPendingF),
    .ex           (exIf.pipe)
  );

endmodule

//--- testbench/armCtrlTb.sv
`timescale 1ns/1ps

module armCtrlTb;

  localparam int clkPeriod   = 10;
  localparam int resetCycles = 4;
  localparam int numInstr    = 2000;

  // Decoded instruction as the model sees it, one per slot
  typedef struct packed {
    logic       valid;      // Real instruction, not a bubble
    logic [3:0] cond;
    logic [1:0] regSrc;
    logic [1:0] immSrc;
    logic       aluSrc;
    logic [3:0] aluCtl;
    logic       regWrite;
    logic       memWrite;
    logic       memToReg;
    logic       branch;
    logic       pcSrc;
    logic [1:0] flagWrite;
    logic       byteAcc;
    logic       store;
  } decT;

  // Memory and writeback slot contents
  typedef struct packed {
    logic       memWrite;  // Unused in writeback
    logic       memToReg;
    logic       regWrite;
    logic       pcSrc;
    logic [3:0] mask;
    logic       byteAcc;
    logic [1:0] offset;
    logic       setFlags;
    logic [3:0] flagsNext;  // NZCV
  } stageT;

  logic        clk;
  logic        rst;
  logic [31:0] instrD;
  logic [3:0]  aluFlagsE;
  logic [1:0]  addrLowE;
  logic        stallE;
  logic        flushE;
  logic        stallM;
  logic        stallW;
  logic        flushW;
  logic [1:0]  regSrcD;
  logic [1:0]  immSrcD;
  logic        aluSrcE;
  logic [3:0]  aluControlE;
  logic        branchTakenE;
  logic        memWriteM;
  logic        memToRegM;
  logic        regWriteM;
  logic [3:0]  byteMaskM;
  logic        memToRegW;
  logic        regWriteW;
  logic        pcSrcW;
  logic        byteLoadW;
  logic [1:0]  byteOffsetW;
  logic [3:0]  flags;
  logic        pcWrPendingF;

  // Model state, mirrors the pipeline registers
  decT        eS;
  stageT      mS;
  stageT      wS;
  logic [3:0] fReg;
  logic [3:0] fwdE;    // Forwarded flags in execute
  logic       passE;   // Condition result in execute
  stageT      memNew;  // What execute hands to memory
  int         cyc;

  armCtrlTop dut (
    .clk(clk), .rst(rst), .instrD(instrD), .aluFlagsE(aluFlagsE), .addrLowE(addrLowE),
    .stallE(stallE), .flushE(flushE), .stallM(stallM), .stallW(stallW), .flushW(flushW),
    .regSrcD(regSrcD), .immSrcD(immSrcD), .aluSrcE(aluSrcE), .aluControlE(aluControlE),
    .branchTakenE(branchTakenE), .memWriteM(memWriteM), .memToRegM(memToRegM),
    .regWriteM(regWriteM), .byteMaskM(byteMaskM), .memToRegW(memToRegW),
    .regWriteW(regWriteW), .pcSrcW(pcSrcW), .byteLoadW(byteLoadW),
    .byteOffsetW(byteOffsetW), .flags(flags), .pcWrPendingF(pcWrPendingF)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  // Watchdog, generous multiple of the stream length
  initial begin
    #((numInstr + 20) * clkPeriod * 4);
    $display("Watchdog expired before the instruction stream finished");
    $display("test failed");
    $fatal(1, "Timeout");
  end

  // ====================================================================
  // Reference rules
  // ====================================================================
  function automatic logic condPasses(logic [3:0] c, logic [3:0] f);
    logic n;
    logic z;
    logic cf;
    logic v;
    n  = f[3];
    z  = f[2];
    cf = f[1];
    v  = f[0];
    case (c)
      4'h0: return z;                 // EQ
      4'h1: return !z;
      4'h2: return cf;                // CS
      4'h3: return !cf;
      4'h4: return n;                 // MI
      4'h5: return !n;
      4'h6: return v;                 // VS
      4'h7: return !v;
      4'h8: return cf && !z;          // HI
      4'h9: return !cf || z;
      4'ha: return n == v;            // GE
      4'hb: return n != v;
      4'hc: return !z && (n == v);    // GT
      4'hd: return z || (n != v);
      4'he: return 1'b1;              // AL
      default: return 1'b0;
    endcase
  endfunction

  function automatic decT decodeInstr(logic [31:0] w);
    decT        d;
    logic [3:0] op;
    logic       isTest;
    logic       isArith;
    d       = '0;
    op      = w[24:21];
    isTest  = (op >= 4'd8) && (op <= 4'd11);  // TST TEQ CMP CMN
    isArith = ((op >= 4'd2) && (op <= 4'd7)) || (op == 4'd10) || (op == 4'd11);
    d.valid  = 1'b1;
    d.cond   = w[31:28];
    d.aluCtl = armIsaPkg::opAdd;
    case (w[27:26])
      armIsaPkg::clsDataProc: begin
        d.aluSrc   = w[25];
        d.aluCtl   = op;  // Opcode straight to the ALU
        d.regWrite = !isTest;
        if (w[20]) begin
          d.flagWrite = isArith ? ctrlPkg::fwAll : ctrlPkg::fwNz;
        end
      end
      armIsaPkg::clsLoadStore: begin
        d.immSrc  = ctrlPkg::immMem;
        d.aluSrc  = !w[25];
        d.byteAcc = w[22];
        d.aluCtl  = w[23] ? armIsaPkg::opAdd : armIsaPkg::opSub;  // Up bit
        if (w[20]) begin  // LDR
          d.regWrite = 1'b1;
          d.memToReg = 1'b1;
        end else begin    // STR
          d.regSrc   = ctrlPkg::regStore;
          d.memWrite = 1'b1;
          d.store    = 1'b1;
        end
      end
      armIsaPkg::clsBranch: begin
        d.regSrc = ctrlPkg::regBranch;
        d.immSrc = ctrlPkg::immBranch;
        d.aluSrc = 1'b1;
        d.branch = 1'b1;
      end
      default: d.branch = 1'b0;
    endcase
    d.pcSrc = d.branch || (d.regWrite && (w[15:12] == 4'hf));  // Write to r15
    return d;
  endfunction

  // Execute stage results on the current inputs
  task automatic evalExecute();
    fwdE = mS.setFlags ? mS.flagsNext : (wS.setFlags ? wS.flagsNext : fReg);
    passE = condPasses(eS.cond, fwdE);
    memNew = '0;
    memNew.memWrite = eS.memWrite && passE;
    memNew.memToReg = eS.memToReg;
    memNew.regWrite = eS.regWrite && passE;
    memNew.pcSrc    = eS.pcSrc && passE;
    memNew.mask     = eS.byteAcc ? (4'b0001 << addrLowE) : 4'hf;
    memNew.byteAcc  = eS.byteAcc;
    memNew.offset   = eS.store ? 2'b00 : addrLowE;
    memNew.setFlags = (eS.flagWrite != ctrlPkg::fwNone) && passE;
    case (eS.flagWrite)
      ctrlPkg::fwAll: memNew.flagsNext = aluFlagsE;
      ctrlPkg::fwNz:  memNew.flagsNext = {aluFlagsE[3:2], fwdE[1:0]};  // C and V held
      default:        memNew.flagsNext = fwdE;
    endcase
  endtask

  // Advance the model by one clock edge
  task automatic stepModel();
    decT        eN;
    stageT      mN;
    stageT      wN;
    logic [3:0] fN;
    eN = eS;
    if (!stallE) eN = decodeInstr(instrD);
    if (rst || flushE) begin  // Bubble, payload fields still load
      eN.valid     = 1'b0;
      eN.regWrite  = 1'b0;
      eN.memWrite  = 1'b0;
      eN.memToReg  = 1'b0;
      eN.branch    = 1'b0;
      eN.pcSrc     = 1'b0;
      eN.flagWrite = ctrlPkg::fwNone;
      eN.byteAcc   = 1'b0;
      eN.store     = 1'b0;
    end
    mN = rst ? stageT'(0) : (stallM ? mS : memNew);
    wN = (rst || flushW) ? stageT'(0) : (stallW ? wS : mS);
    fN = fReg;
    if (rst) fN = 4'h0;
    else if (wS.setFlags && !stallW) fN = wS.flagsNext;
    eS   = eN;
    mS   = mN;
    wS   = wN;
    fReg = fN;
  endtask

  // ====================================================================
  // Checks
  // ====================================================================
  task automatic checkEq(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h (cycle %0d)", name, got, exp, cyc);
      $display("test failed");
      $fatal(1, "Stopping at first error");
    end
  endtask

  task automatic checkOutputs();
    decT d;
    d = decodeInstr(instrD);
    checkEq("regSrcD", regSrcD, d.regSrc);
    checkEq("immSrcD", immSrcD, d.immSrc);
    if (eS.valid) begin  // Bubble payload is don't care
      checkEq("aluSrcE", aluSrcE, eS.aluSrc);
      checkEq("aluControlE", aluControlE, eS.aluCtl);
    end
    checkEq("branchTakenE", branchTakenE, eS.branch && passE);
    checkEq("memWriteM", memWriteM, mS.memWrite);
    checkEq("memToRegM", memToRegM, mS.memToReg);
    checkEq("regWriteM", regWriteM, mS.regWrite);
    checkEq("byteMaskM", byteMaskM, mS.mask);
    checkEq("memToRegW", memToRegW, wS.memToReg);
    checkEq("regWriteW", regWriteW, wS.regWrite);
    checkEq("pcSrcW", pcSrcW, wS.pcSrc);
    checkEq("byteLoadW", byteLoadW, wS.byteAcc);
    checkEq("byteOffsetW", byteOffsetW, wS.offset);
    checkEq("flags", flags, fReg);
    checkEq("pcWrPendingF", pcWrPendingF, d.pcSrc || eS.pcSrc || mS.pcSrc);
  endtask

  // Fixed values straight after reset
  task automatic checkResetState();
    checkEq("regWriteM", regWriteM, 0);
    checkEq("memWriteM", memWriteM, 0);
    checkEq("regWriteW", regWriteW, 0);
    checkEq("pcSrcW", pcSrcW, 0);
    checkEq("branchTakenE", branchTakenE, 0);
    checkEq("flags", flags, 0);
  endtask

  task automatic driveRandom();
    logic [31:0] w;
    w = $urandom;
    if ($urandom % 2) w[31:28] = 4'he;  // Half AL
    else w[31:28] = $urandom % 15;      // Never the 1111 space
    w[27:26] = $urandom % 3;            // DP, LDR/STR, B
    instrD    <= w;
    aluFlagsE <= $urandom;
    addrLowE  <= $urandom;
    stallE    <= ($urandom % 16) == 0;
    flushE    <= ($urandom % 24) == 0;
    stallM    <= ($urandom % 16) == 0;
    stallW    <= ($urandom % 16) == 0;
    flushW    <= ($urandom % 24) == 0;
  endtask

  // ====================================================================
  // Stimulus, model sampled on the falling edge
  // ====================================================================
  initial begin
    void'($urandom(32'h9cd1_34ab));
    rst       = 1'b1;
    instrD    = '0;
    aluFlagsE = '0;
    addrLowE  = '0;
    stallE    = 1'b0;
    flushE    = 1'b0;
    stallM    = 1'b0;
    stallW    = 1'b0;
    flushW    = 1'b0;
    eS   = '0;
    mS   = '0;
    wS   = '0;
    fReg = '0;
    cyc  = 0;
    evalExecute();
    stepModel();  // First edge sees these values
    for (cyc = 0; cyc < resetCycles - 1 + numInstr; cyc++) begin
      @(posedge clk);
      if (cyc >= resetCycles - 1) begin  // rst drops after this edge samples it
        rst <= 1'b0;
        driveRandom();
      end
      @(negedge clk);
      evalExecute();
      checkOutputs();
      if (cyc == resetCycles - 1) checkResetState();
      stepModel();
    end
    $display("test passed");
    $finish;
  end

endmodule

//--- vlog.f
source/armIsaPkg.sv
source/ctrlPkg.sv
source/execCtrlIf.sv
source/instrDecoder.sv
source/condCheck.sv
source/memMask.sv
source/ctrlPipe.sv
source/armCtrlTop.sv
testbench/armCtrlTb.sv
